//--- hdl/gcm_pkg.sv
// Widths, types and constants shared by the GHASH datapath
// The first message byte sits in bits 127:120 of a block
// Keep bit i qualifies bits i*8+7 down to i*8
package gcm_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int BLOCK_W    = 128;
    localparam int KEEP_W     = 16;
    localparam int LEN_W      = 64;

    // Bit counter of the serial multiplier
    localparam int MULT_CNT_W = $clog2(BLOCK_W);

    // ------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------
    typedef logic [BLOCK_W-1:0] gcm_block_t;
    typedef logic [KEEP_W-1:0]  gcm_keep_t;
    typedef logic [LEN_W-1:0]   gcm_len_t;

    // Message sequencing
    typedef enum logic [2:0] {
        PH_IDLE    = 3'd0,
        PH_AAD     = 3'd1,
        PH_PAYLOAD = 3'd2,
        PH_LEN     = 3'd3,
        PH_WAIT    = 3'd4,
        PH_DONE    = 3'd5
    } gcm_phase_e;

    // ------------------------------------------------------------------
    // GF(2^128) reduction, x^128 + x^7 + x^2 + x + 1 in GCM bit order
    // ------------------------------------------------------------------
    localparam gcm_block_t GF_R = {8'he1, 120'h0};

endpackage

//--- hdl/gcm_block_if.sv
// One block per valid/ready transfer; source holds its outputs until ready
// last is only set on the length block of a message
`timescale 1ns/1ps

interface gcm_block_if
    import gcm_pkg::*;
();

    logic       valid;
    logic       ready;
    gcm_block_t data;
    logic       last;

    // Block producer
    modport src (
        output valid,
        output data,
        output last,
        input  ready
    );

    // Block consumer
    modport dst (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

//--- hdl/gf128_mult.sv
// Bit-serial GF(2^128) multiply in GCM bit order, one bit of x per cycle
// done pulses 128 cycles after start; z is only valid while done is high or after
`timescale 1ns/1ps

module gf128_mult
    import gcm_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  gcm_block_t x,
    input  gcm_block_t y,
    output logic       done,
    output gcm_block_t z
);

    logic                  running;
    logic [MULT_CNT_W-1:0] cnt;
    gcm_block_t            x_sh;
    gcm_block_t            v;
    gcm_block_t            x_cur;
    gcm_block_t            v_cur;
    gcm_block_t            z_cur;

    // First bit is processed on the start edge itself
    assign x_cur = start ? x : x_sh;
    assign v_cur = start ? y : v;
    assign z_cur = start ? '0 : z;

    // ------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (start || running) begin
            z    <= z_cur ^ (x_cur[BLOCK_W-1] ? v_cur : '0);
            // Multiply v by x, reduce when a bit falls off the end
            v    <= (v_cur >> 1) ^ (v_cur[0] ? GF_R : '0);
            x_sh <= x_cur << 1;
        end
    end

    // ------------------------------------------------------------------
    // Bit counter
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            cnt     <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                // 127 more bits after the start edge
                if (cnt == MULT_CNT_W'(BLOCK_W - 2)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/ghash_accum.sv
// GHASH accumulator Y = (Y ^ block) * H, one block per 130 cycles
// H must be loaded before start; Y is cleared by msg_start
`timescale 1ns/1ps

module ghash_accum
    import gcm_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  gcm_block_t h_key,
    input  logic       h_we,
    input  logic       msg_start,
    gcm_block_if.dst   blk,
    output gcm_block_t tag_pre_xor,
    output logic       tag_pre_xor_valid,
    output logic       ghash_done
);

    typedef enum logic [1:0] {
        ACC_IDLE  = 2'd0,
        ACC_MULT  = 2'd1,
        ACC_LATCH = 2'd2
    } acc_state_e;

    acc_state_e state;
    gcm_block_t h_q;
    gcm_block_t y_q;
    gcm_block_t mult_x;
    gcm_block_t prod;
    logic       xfer;
    logic       mult_done;
    logic       last_q;

    assign blk.ready = (state == ACC_IDLE);
    assign xfer      = blk.valid & blk.ready;
    assign mult_x    = y_q ^ blk.data;

    gf128_mult u_gf_mult (
        .clk   (clk),
        .rst_n (rst_n),
        .start (xfer),
        .x     (mult_x),
        .y     (h_q),
        .done  (mult_done),
        .z     (prod)
    );

    // ------------------------------------------------------------------
    // Hash subkey and running Y
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (h_we) begin
            h_q <= h_key;
        end
    end

    always_ff @(posedge clk) begin
        if (msg_start) begin
            y_q <= '0;
        end else if (mult_done) begin
            y_q <= prod;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ACC_LATCH && last_q) begin
            tag_pre_xor <= y_q;
        end
    end

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state             <= ACC_IDLE;
            last_q            <= 1'b0;
            tag_pre_xor_valid <= 1'b0;
            ghash_done        <= 1'b0;
        end else begin
            ghash_done <= 1'b0;
            if (msg_start) begin
                tag_pre_xor_valid <= 1'b0;
            end
            case (state)
                ACC_IDLE: begin
                    if (xfer) begin
                        state  <= ACC_MULT;
                        last_q <= blk.last;
                    end
                end
                ACC_MULT: begin
                    if (mult_done) begin
                        state <= ACC_LATCH;
                    end
                end
                default: begin
                    // Product of the length block is the tag
                    state <= ACC_IDLE;
                    if (last_q) begin
                        tag_pre_xor_valid <= 1'b1;
                        ghash_done        <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

//--- hdl/gcm_block_select.sv
// Sequences AAD, payload and length blocks of one message into GHASH
// Stream lengths must agree with the captured bit counts; a new start drops a held block
`timescale 1ns/1ps

module gcm_block_select
    import gcm_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  gcm_len_t   len_aad_bits,
    input  gcm_len_t   len_pld_bits,
    input  logic       aad_valid,
    output logic       aad_ready,
    input  logic       aad_last,
    input  gcm_block_t aad_data,
    input  gcm_keep_t  aad_keep,
    input  logic       din_valid,
    output logic       din_ready,
    input  logic       din_last,
    input  gcm_block_t din_data,
    input  gcm_keep_t  din_keep,
    gcm_block_if.src   blk,
    input  logic       ghash_done,
    output logic       msg_start,
    output logic       aad_done,
    output logic       pld_done,
    output logic       lens_done
);

    function automatic gcm_block_t mask_block(input gcm_block_t data, input gcm_keep_t keep);
        gcm_block_t res;
        for (int i = 0; i < KEEP_W; i++) begin
            res[i*8 +: 8] = keep[i] ? data[i*8 +: 8] : 8'h00;
        end
        return res;
    endfunction

    logic       start_d;
    logic       start_pulse;
    gcm_len_t   len_aad_q;
    gcm_len_t   len_pld_q;
    gcm_phase_e phase;
    gcm_phase_e phase_nxt;
    gcm_block_t hold_data;
    logic       hold_valid;
    logic       hold_pld_last;
    logic       hold_free;
    logic       blk_xfer;
    logic       hold_xfer;
    logic       len_xfer;
    logic       aad_xfer;
    logic       din_xfer;
    gcm_block_t len_block;

    // ------------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------------
    assign start_pulse = start & ~start_d;
    assign msg_start   = start_pulse;

    assign blk_xfer  = blk.valid & blk.ready;
    assign hold_xfer = blk_xfer & hold_valid;
    assign len_xfer  = blk_xfer & ~hold_valid & (phase == PH_LEN);

    // Accept only when the holding register is empty or draining
    assign hold_free = ~hold_valid | hold_xfer;
    assign aad_ready = (phase == PH_AAD) & hold_free;
    assign din_ready = (phase == PH_PAYLOAD) & hold_free;
    assign aad_xfer  = aad_valid & aad_ready;
    assign din_xfer  = din_valid & din_ready;

    assign len_block = {len_aad_q, len_pld_q};

    // Held block goes first, the length block follows once it has drained
    assign blk.valid = hold_valid | (phase == PH_LEN);
    assign blk.data  = hold_valid ? hold_data : len_block;
    assign blk.last  = ~hold_valid & (phase == PH_LEN);

    // ------------------------------------------------------------------
    // Start capture
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_d <= 1'b0;
        end else begin
            start_d <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start_pulse) begin
            len_aad_q <= len_aad_bits;
            len_pld_q <= len_pld_bits;
        end
    end

    // ------------------------------------------------------------------
    // Holding register
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid    <= 1'b0;
            hold_pld_last <= 1'b0;
        end else if (start_pulse) begin
            hold_valid    <= 1'b0;
            hold_pld_last <= 1'b0;
        end else if (aad_xfer | din_xfer) begin
            hold_valid    <= 1'b1;
            hold_pld_last <= din_xfer & din_last;
        end else if (hold_xfer) begin
            hold_valid    <= 1'b0;
            hold_pld_last <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aad_xfer) begin
            hold_data <= mask_block(aad_data, aad_keep);
        end else if (din_xfer) begin
            hold_data <= mask_block(din_data, din_keep);
        end
    end

    // ------------------------------------------------------------------
    // Phase FSM
    // ------------------------------------------------------------------
    always_comb begin
        phase_nxt = phase;
        if (start_pulse) begin
            if (len_aad_bits != '0) begin
                phase_nxt = PH_AAD;
            end else if (len_pld_bits != '0) begin
                phase_nxt = PH_PAYLOAD;
            end else begin
                phase_nxt = PH_LEN;
            end
        end else begin
            case (phase)
                PH_AAD: begin
                    // Skip an empty payload section
                    if (aad_xfer && aad_last) begin
                        phase_nxt = (len_pld_q == '0) ? PH_LEN : PH_PAYLOAD;
                    end
                end
                PH_PAYLOAD: begin
                    if (hold_xfer && hold_pld_last) begin
                        phase_nxt = PH_LEN;
                    end
                end
                PH_LEN: begin
                    if (len_xfer) begin
                        phase_nxt = PH_WAIT;
                    end
                end
                PH_WAIT: begin
                    if (ghash_done) begin
                        phase_nxt = PH_DONE;
                    end
                end
                default: begin
                    phase_nxt = PH_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_IDLE;
        end else begin
            phase <= phase_nxt;
        end
    end

    // Progress flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aad_done  <= 1'b0;
            pld_done  <= 1'b0;
            lens_done <= 1'b0;
        end else if (start_pulse) begin
            aad_done  <= (len_aad_bits == '0);
            pld_done  <= (len_pld_bits == '0);
            lens_done <= 1'b0;
        end else begin
            if (aad_xfer && aad_last) begin
                aad_done <= 1'b1;
            end
            if (din_xfer && din_last) begin
                pld_done <= 1'b1;
            end
            if (len_xfer) begin
                lens_done <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/gcm_ghash_top.sv
// GCM GHASH top; H comes in through h_key/h_we, no AES core inside
// tag_pre_xor still needs the E(K, J0) mask to become the GCM tag
`timescale 1ns/1ps

module gcm_ghash_top
    import gcm_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  gcm_block_t h_key,
    input  logic       h_we,
    input  logic       start,
    input  gcm_len_t   len_aad_bits,
    input  gcm_len_t   len_pld_bits,
    input  logic       aad_valid,
    output logic       aad_ready,
    input  logic       aad_last,
    input  gcm_block_t aad_data,
    input  gcm_keep_t  aad_keep,
    input  logic       din_valid,
    output logic       din_ready,
    input  logic       din_last,
    input  gcm_block_t din_data,
    input  gcm_keep_t  din_keep,
    output gcm_block_t tag_pre_xor,
    output logic       tag_pre_xor_valid,
    output logic       aad_done,
    output logic       pld_done,
    output logic       lens_done
);

    logic msg_start;
    logic ghash_done;

    gcm_block_if u_blk_if ();

    gcm_block_select u_select (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .len_aad_bits (len_aad_bits),
        .len_pld_bits (len_pld_bits),
        .aad_valid    (aad_valid),
        .aad_ready    (aad_ready),
        .aad_last     (aad_last),
        .aad_data     (aad_data),
        .aad_keep     (aad_keep),
        .din_valid    (din_valid),
        .din_ready    (din_ready),
        .din_last     (din_last),
        .din_data     (din_data),
        .din_keep     (din_keep),
        .blk          (u_blk_if.src),
        .ghash_done   (ghash_done),
        .msg_start    (msg_start),
        .aad_done     (aad_done),
        .pld_done     (pld_done),
        .lens_done    (lens_done)
    );

    ghash_accum u_accum (
        .clk               (clk),
        .rst_n             (rst_n),
        .h_key             (h_key),
        .h_we              (h_we),
        .msg_start         (msg_start),
        .blk               (u_blk_if.dst),
        .tag_pre_xor       (tag_pre_xor),
        .tag_pre_xor_valid (tag_pre_xor_valid),
        .ghash_done        (ghash_done)
    );

endmodule

//--- test/tb_clock_gen.sv
// 100 ns clock, active-low reset held for the first 4 rising edges
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Release just after the edge so no flop sees it at the same time
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- test/gcm_ghash_sva.sv
// Assertions on the block interface and tag flag of ghash_accum
// A held block may only be dropped by msg_start
`timescale 1ns/1ps

module gcm_ghash_sva
    import gcm_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       valid,
    input logic       ready,
    input gcm_block_t data,
    input logic       mult_busy,
    input logic       msg_start,
    input logic       tag_valid
);

    // Source holds the block until the accumulator takes it
    property blk_held;
        @(posedge clk) disable iff (!rst_n)
        valid && !ready && !msg_start |=> valid && $stable(data);
    endproperty

    property busy_not_ready;
        @(posedge clk) disable iff (!rst_n)
        mult_busy |-> !ready;
    endproperty

    property tag_valid_fall;
        @(posedge clk) disable iff (!rst_n)
        $fell(tag_valid) |-> $past(msg_start);
    endproperty

    assert property (blk_held) else $error("block dropped or changed before ready");
    assert property (busy_not_ready) else $error("ready high while multiplier runs");
    assert property (tag_valid_fall) else $error("tag_pre_xor_valid fell without msg_start");

endmodule

//--- test/gcm_ghash_tb.sv
// Table-driven GHASH testbench with its own bit-serial reference model
// Partial keep only on a section's last block; kept bytes are the leading ones
`timescale 1ns/1ps

module gcm_ghash_tb
    import gcm_pkg::*;
();

    typedef struct {
        gcm_block_t h;
        int         n_aad;
        int         n_pld;
        gcm_keep_t  aad_keep;
        gcm_keep_t  pld_keep;
        bit         gaps;
        bit         reuse;
    } case_t;

    logic       clk;
    logic       rst_n;
    gcm_block_t h_key;
    logic       h_we;
    logic       start;
    gcm_len_t   len_aad_bits;
    gcm_len_t   len_pld_bits;
    logic       aad_valid;
    logic       aad_ready;
    logic       aad_last;
    gcm_block_t aad_data;
    gcm_keep_t  aad_keep;
    logic       din_valid;
    logic       din_ready;
    logic       din_last;
    gcm_block_t din_data;
    gcm_keep_t  din_keep;
    gcm_block_t tag_pre_xor;
    logic       tag_pre_xor_valid;
    logic       aad_done;
    logic       pld_done;
    logic       lens_done;

    case_t      cases [0:4];
    gcm_block_t aad_q [$];
    gcm_block_t pld_q [$];
    gcm_block_t prev_tag;
    integer     seed = 32'h3da3d310;
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    int         cycle_limit = 0;

    tb_clock_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    gcm_ghash_top dut (
        .clk(clk), .rst_n(rst_n), .h_key(h_key), .h_we(h_we), .start(start),
        .len_aad_bits(len_aad_bits), .len_pld_bits(len_pld_bits),
        .aad_valid(aad_valid), .aad_ready(aad_ready), .aad_last(aad_last),
        .aad_data(aad_data), .aad_keep(aad_keep),
        .din_valid(din_valid), .din_ready(din_ready), .din_last(din_last),
        .din_data(din_data), .din_keep(din_keep),
        .tag_pre_xor(tag_pre_xor), .tag_pre_xor_valid(tag_pre_xor_valid),
        .aad_done(aad_done), .pld_done(pld_done), .lens_done(lens_done)
    );

    bind ghash_accum gcm_ghash_sva u_sva (
        .clk(clk), .rst_n(rst_n), .valid(blk.valid), .ready(blk.ready), .data(blk.data),
        .mult_busy(u_gf_mult.running), .msg_start(msg_start), .tag_valid(tag_pre_xor_valid)
    );

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    // GCM multiply with bit 127 as the x^0 coefficient
    function automatic gcm_block_t gf_mul(input gcm_block_t a, input gcm_block_t b);
        gcm_block_t acc;
        gcm_block_t sh;
        acc = '0;
        sh  = b;
        for (int i = 127; i >= 0; i--) begin
            if (a[i]) acc ^= sh;
            sh = sh[0] ? ((sh >> 1) ^ {8'he1, 120'h0}) : (sh >> 1);
        end
        return acc;
    endfunction

    function automatic gcm_block_t apply_keep(input gcm_block_t d, input gcm_keep_t k);
        gcm_block_t m;
        for (int b = 0; b < 16; b++) m[b*8 +: 8] = {8{k[b]}};
        return d & m;
    endfunction

    function automatic gcm_len_t section_bits(input int n, input gcm_keep_t last_keep);
        int bytes;
        if (n == 0) return '0;
        bytes = (n - 1) * 16 + $countones(last_keep);
        return gcm_len_t'(bytes * 8);
    endfunction

    function automatic gcm_block_t model_ghash(input case_t c);
        gcm_block_t y;
        y = '0;
        foreach (aad_q[i])
            y = gf_mul(y ^ apply_keep(aad_q[i], (i == c.n_aad - 1) ? c.aad_keep : 16'hffff), c.h);
        foreach (pld_q[i])
            y = gf_mul(y ^ apply_keep(pld_q[i], (i == c.n_pld - 1) ? c.pld_keep : 16'hffff), c.h);
        return gf_mul(y ^ {section_bits(c.n_aad, c.aad_keep),
                           section_bits(c.n_pld, c.pld_keep)}, c.h);
    endfunction

    function automatic gcm_block_t rand_block();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // ------------------------------------------------------------------
    // Checks and drivers
    // ------------------------------------------------------------------
    task automatic check_block(input gcm_block_t got, input gcm_block_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic send_block(input bit pld, input gcm_block_t d, input gcm_keep_t k,
                              input bit last, input bit gaps);
        int gap;
        bit taken;
        gap = gaps ? ($random(seed) & 3) : 0;
        repeat (gap) next_cycle();
        if (pld) begin
            din_valid = 1'b1;
            din_data  = d;
            din_keep  = k;
            din_last  = last;
        end else begin
            aad_valid = 1'b1;
            aad_data  = d;
            aad_keep  = k;
            aad_last  = last;
        end
        taken = 1'b0;
        // Transfer on the edge after ready is seen
        while (!taken) begin
            @(negedge clk);
            taken = pld ? din_ready : aad_ready;
            next_cycle();
        end
        din_valid = 1'b0;
        aad_valid = 1'b0;
        din_last  = 1'b0;
        aad_last  = 1'b0;
    endtask

    task automatic run_case(input case_t c, input int idx);
        gcm_block_t exp_tag;
        if (!c.reuse) begin
            aad_q.delete();
            pld_q.delete();
            repeat (c.n_aad) aad_q.push_back(rand_block());
            repeat (c.n_pld) pld_q.push_back(rand_block());
        end
        exp_tag = model_ghash(c);
        h_key = c.h;
        h_we  = 1'b1;
        next_cycle();
        h_we         = 1'b0;
        len_aad_bits = section_bits(c.n_aad, c.aad_keep);
        len_pld_bits = section_bits(c.n_pld, c.pld_keep);
        start        = 1'b1;
        next_cycle();
        start = 1'b0;
        check_flag(tag_pre_xor_valid, 1'b0, $sformatf("case %0d tag valid after start", idx));
        check_flag(lens_done, 1'b0, $sformatf("case %0d lens_done after start", idx));
        check_flag(aad_done, c.n_aad == 0, $sformatf("case %0d aad_done after start", idx));
        check_flag(pld_done, c.n_pld == 0, $sformatf("case %0d pld_done after start", idx));
        foreach (aad_q[i])
            send_block(1'b0, aad_q[i], (i == c.n_aad - 1) ? c.aad_keep : 16'hffff,
                       i == c.n_aad - 1, c.gaps);
        foreach (pld_q[i])
            send_block(1'b1, pld_q[i], (i == c.n_pld - 1) ? c.pld_keep : 16'hffff,
                       i == c.n_pld - 1, c.gaps);
        while (!tag_pre_xor_valid) @(negedge clk);
        check_block(tag_pre_xor, exp_tag, $sformatf("case %0d tag", idx));
        check_flag(lens_done, 1'b1, $sformatf("case %0d lens_done at end", idx));
        check_flag(aad_done, 1'b1, $sformatf("case %0d aad_done at end", idx));
        check_flag(pld_done, 1'b1, $sformatf("case %0d pld_done at end", idx));
        if (c.reuse) check_block(tag_pre_xor, prev_tag, $sformatf("case %0d repeat tag", idx));
        prev_tag = tag_pre_xor;
        next_cycle();
    endtask

    // Watchdog
    always @(posedge clk) begin
        if (rst_n) cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        {h_key, h_we, start, len_aad_bits, len_pld_bits} = '0;
        {aad_valid, aad_last, aad_data, aad_keep} = '0;
        {din_valid, din_last, din_data, din_keep} = '0;
        // H, AAD blocks, payload blocks, last keeps, valid gaps, repeat previous data
        cases[0] = '{128'h66e94bd4ef8a2c3b884cfa59ca342b2e, 0, 0, 16'hffff, 16'hffff, 0, 0};
        cases[1] = '{128'hb83b533708bf535d0aa6e52980d53b78, 3, 0, 16'hffc0, 16'hffff, 0, 0};
        cases[2] = '{128'h25629347589242761d31f826ba4b757b, 2, 4, 16'hffff, 16'hfff0, 0, 0};
        cases[3] = '{128'h25629347589242761d31f826ba4b757b, 2, 4, 16'hffff, 16'hfff0, 1, 1};
        cases[4] = '{128'hacbef20579b4b8ebce889bac8732dad7, 1, 2, 16'hf000, 16'hff00, 0, 0};
        // One length block per case plus slack for H loads and starts
        foreach (cases[i]) cycle_limit += (cases[i].n_aad + cases[i].n_pld + 1) * 140;
        cycle_limit += 200;

        wait (rst_n === 1'b1);
        @(negedge clk);
        check_flag(aad_ready, 1'b0, "aad_ready after reset");
        check_flag(din_ready, 1'b0, "din_ready after reset");
        check_flag(tag_pre_xor_valid, 1'b0, "tag valid after reset");
        check_flag(aad_done, 1'b0, "aad_done after reset");
        check_flag(pld_done, 1'b0, "pld_done after reset");
        check_flag(lens_done, 1'b0, "lens_done after reset");
        next_cycle();

        foreach (cases[i]) run_case(cases[i], i);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- gcm_ghash_top.f
hdl/gcm_pkg.sv
hdl/gcm_block_if.sv
hdl/gf128_mult.sv
hdl/ghash_accum.sv
hdl/gcm_block_select.sv
hdl/gcm_ghash_top.sv
test/tb_clock_gen.sv
test/gcm_ghash_sva.sv
test/gcm_ghash_tb.sv

//--- Makefile
# Verilator build and run of the GHASH testbench
VERILATOR ?= verilator
TOP       ?= gcm_ghash_tb
FILELIST  ?= gcm_ghash_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /$(PASS_MSG)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
